//--- src.f
hdl/rv_pkg.sv
hdl/core_sequencer.sv
hdl/inst_decoder.sv
hdl/int_reg_file.sv
hdl/int_alu.sv
hdl/load_store_unit.sv
hdl/rv_core.sv
bench/core_checker.sv
bench/tb_rv_core.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" &&
	verilator --binary --timing -f src.f --top-module tb_rv_core \
		-o tb_rv_core > build.log 2>&1 &&
	./obj_dir/tb_rv_core > sim.log 2>&1 ||
	{ echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "Simulation PASSED" sim.log && echo "run passed" ||
	{ echo "run failed, see sim.log"; exit 1; }

//--- bench/tb_rv_core.sv
`default_nettype none
`timescale 1ns/1ps

module tb_rv_core import rv_pkg::*; ();

	localparam int prog_len = 200;
	localparam int data_base = 'h400; // 256-byte data region
	localparam int run_limit = 200000;

	typedef enum logic [3:0] {
		k_reg, k_imm, k_lui, k_auipc, k_branch, k_jal, k_load, k_store,
		k_sw, k_nop, k_set_base, k_jalr, k_end
	} kind_t;

	logic clk;
	logic rstn;
	logic mem_req;
	logic [xlen-1:0] mem_addr;
	logic mem_we;
	logic [3:0] mem_wstrb;
	logic [xlen-1:0] mem_wdata;
	logic mem_ack;
	logic [xlen-1:0] mem_rdata;
	logic chk_done;
	int chk_errors;
	int chk_checks;
	logic [31:0] lfsr;
	logic [31:0] mem [0:1023];
	kind_t kind [0:prog_len];
	logic mem_hung;
	logic timed_out;

	rv_core rv_core_inst (
		.clk(clk), .rstn(rstn),
		.mem_req(mem_req), .mem_addr(mem_addr), .mem_we(mem_we),
		.mem_wstrb(mem_wstrb), .mem_wdata(mem_wdata),
		.mem_ack(mem_ack), .mem_rdata(mem_rdata)
	);

	core_checker checker_inst (
		.clk(clk), .rstn(rstn),
		.mem_req(mem_req), .mem_addr(mem_addr), .mem_we(mem_we),
		.mem_wstrb(mem_wstrb), .mem_wdata(mem_wdata),
		.mem_ack(mem_ack), .mem_rdata(mem_rdata),
		.done(chk_done), .errors(chk_errors), .checks(chk_checks)
	);

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = 32'd0;
		repeat (n) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	function automatic logic [31:0] branch_word(input logic [31:0] off, input logic [31:0] rs2,
			input logic [31:0] rs1, input logic [31:0] f3);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], opc_branch};
	endfunction

	function automatic logic [31:0] jal_word(input logic [31:0] off, input logic [31:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], opc_jal};
	endfunction

	// forward jump of 1 to 8 slots that never lands on a jalr
	task automatic forward_offset(input int i, output logic [31:0] off);
		logic [31:0] n;
		int t;
		rand_bits(3, n);
		t = i + 1 + int'(n);
		if (t > prog_len)
			t = prog_len;
		if (kind[t] == k_jalr)
			t = t - 1;
		off = (t - i) * 4;
	endtask

	task automatic encode_slot(input int i, output logic [31:0] w);
		logic [31:0] rd, rs1, rs2, f3, v, off;
		rand_bits(4, rs1);
		rand_bits(4, rs2);
		rand_bits(4, rd);
		rd = 1 + rd % 14; // x15 holds jalr targets
		rand_bits(3, f3);
		rand_bits(8, off);
		case (kind[i])
			k_reg: begin
				rand_bits(1, v);
				if (f3 != 0 && f3 != 5)
					v = 0;
				w = {1'b0, v[0], 5'd0, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc_op};
			end
			k_imm: begin
				rand_bits(12, v);
				if (f3 == 1)
					v = v & 32'h1f;
				else if (f3 == 5)
					v = v & 32'h41f;
				w = {v[11:0], rs1[4:0], f3[2:0], rd[4:0], opc_op_imm};
			end
			k_lui, k_auipc: begin
				rand_bits(20, v);
				w = {v[19:0], rd[4:0], kind[i] == k_lui ? opc_lui : opc_auipc};
			end
			k_branch: begin
				if (f3 == 2 || f3 == 3)
					f3 = f3 + 2;
				forward_offset(i, v);
				w = branch_word(v, rs2, rs1, f3);
			end
			k_jal: begin
				forward_offset(i, v);
				w = jal_word(v, rd);
			end
			k_load: begin
				if (f3 == 3 || f3 >= 6)
					f3 = 2;
				off = off & (f3[1:0] == 2'd2 ? 32'hfc : f3[0] ? 32'hfe : 32'hff);
				v = data_base + off;
				w = {v[11:0], 5'd0, f3[2:0], rd[4:0], opc_load};
			end
			k_store, k_sw: begin
				f3 = (kind[i] == k_sw) ? 2 : f3 % 3;
				off = off & (f3 == 2 ? 32'hfc : f3 == 1 ? 32'hfe : 32'hff);
				v = data_base + off;
				w = {v[11:5], rs2[4:0], 5'd0, f3[2:0], v[4:0], opc_store};
			end
			k_nop: w = {12'h300, rs1[4:0], 3'b001, rd[4:0], 7'b1110011}; // csrrw
			k_set_base: begin
				forward_offset(i + 1, off);
				v = (i + 1) * 4 + off;
				w = {v[11:0], 5'd0, 3'b000, 5'd15, opc_op_imm};
			end
			k_jalr: w = {12'd0, 5'd15, 3'b000, rd[4:0], opc_jalr};
			default: w = jal_word(32'd0, 32'd0); // jump to itself
		endcase
	endtask

	task automatic build_program();
		logic [31:0] r;
		int i;
		for (int a = 0; a < 1024; a++)
			mem[a] = (a * 32'h9e3779b1) ^ 32'hc3a55a3c;
		i = 0;
		while (i < prog_len) begin
			if (i % 8 == 7) begin
				kind[i] = k_sw;
			end else begin
				rand_bits(4, r);
				if (r == 0 && i % 8 <= 5) begin
					kind[i] = k_set_base;
					kind[i + 1] = k_jalr;
					i++;
				end else if (r <= 3) kind[i] = k_reg;
				else if (r <= 6) kind[i] = k_imm;
				else if (r == 7) kind[i] = k_lui;
				else if (r == 8) kind[i] = k_auipc;
				else if (r <= 10) kind[i] = k_branch;
				else if (r == 11) kind[i] = k_jal;
				else if (r <= 13) kind[i] = k_load;
				else if (r == 14) kind[i] = k_store;
				else kind[i] = k_nop;
			end
			i++;
		end
		kind[prog_len] = k_end;
		for (int s = 0; s <= prog_len; s++)
			encode_slot(s, mem[s]);
	endtask

	task automatic end_run();
		$display("checks %0d errors %0d", chk_checks, chk_errors);
		if (chk_errors == 0 && !timed_out && !mem_hung)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// memory side of the four-phase handshake
	initial begin
		logic [31:0] d;
		logic [9:0] idx;
		int n;
		forever begin
			@(posedge clk);
			if (rstn && mem_req && !mem_ack) begin
				rand_bits(2, d);
				repeat (d) @(posedge clk);
				idx = mem_addr[11:2];
				mem_rdata <= mem[idx]; // old word on writes too
				mem_ack <= 1'b1;
				if (mem_we)
					for (int k = 0; k < 4; k++)
						if (mem_wstrb[k])
							mem[idx][8*k +: 8] = mem_wdata[8*k +: 8];
				n = 0;
				while (mem_req && n < 64) begin
					@(posedge clk);
					n++;
				end
				if (mem_req) begin
					$display("ERROR: core kept mem_req high after mem_ack");
					mem_hung = 1'b1;
				end
				rand_bits(2, d);
				repeat (d) @(posedge clk);
				mem_ack <= 1'b0;
			end
		end
	end

	initial begin
		int n;
		lfsr = 32'd81338;
		mem_hung = 1'b0;
		timed_out = 1'b0;
		rstn <= 1'b0;
		mem_ack <= 1'b0;
		mem_rdata <= '0;
		build_program();
		repeat (5) @(posedge clk);
		rstn <= 1'b1;
		n = 0;
		while (!chk_done && !mem_hung && n < run_limit) begin
			@(negedge clk);
			n++;
		end
		if (!chk_done && !mem_hung) begin
			$display("ERROR: program did not reach its final self-jump in time");
			timed_out = 1'b1;
		end
		end_run();
	end

endmodule

`default_nettype wire

//--- bench/core_checker.sv
`default_nettype none
`timescale 1ns/1ps

module core_checker import rv_pkg::*; (
	input logic clk,
	input logic rstn,
	input logic mem_req,
	input logic [xlen-1:0] mem_addr,
	input logic mem_we,
	input logic [3:0] mem_wstrb,
	input logic [xlen-1:0] mem_wdata,
	input logic mem_ack,
	input logic [xlen-1:0] mem_rdata,
	output logic done,
	output int errors,
	output int checks
);

	int err_cnt = 0;
	int chk_cnt = 0;
	logic [31:0] x [0:31]; // model register file
	logic [31:0] pc;
	logic [31:0] mem_copy [0:1023];
	logic known [0:1023]; // word already seen on the bus
	logic expect_data;
	logic d_store;
	logic [31:0] d_addr;
	logic [31:0] d_val;
	logic [2:0] d_f3;
	logic [4:0] d_rd;
	logic served;
	logic prev_req;
	logic [68:0] prev_bus;

	assign errors = err_cnt;
	assign checks = chk_cnt;

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		chk_cnt++;
		if (exp !== act) begin
			err_cnt++;
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic report_failure(input string msg);
		err_cnt++;
		$display("ERROR: %s", msg);
	endtask

	task automatic write_reg(input logic [4:0] rd, input logic [31:0] v);
		if (rd != 5'd0)
			x[rd] = v;
	endtask

	function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		logic [31:0] r;
		logic [4:0] sh;
		sh = b[4:0];
		case (f3)
			3'd0: r = alt ? a - b : a + b;
			3'd1: r = a << sh;
			3'd2: r = {31'd0, $signed(a) < $signed(b)};
			3'd3: r = {31'd0, a < b};
			3'd4: r = a ^ b;
			3'd5: begin
				if (alt)
					r = $signed(a) >>> sh;
				else
					r = a >> sh;
			end
			3'd6: r = a | b;
			default: r = a & b;
		endcase
		return r;
	endfunction

	task automatic fetch_and_execute();
		logic [31:0] ins, a, b, ii, is, ib, iu, ij, npc;
		logic [4:0] rd;
		logic [2:0] f3;
		logic clean;
		logic take;
		check_value("fetch_addr", pc, mem_addr);
		check_value("fetch_we", 32'd0, {31'd0, mem_we});
		check_value("fetch_wstrb", 32'd0, {28'd0, mem_wstrb});
		ins = mem_rdata;
		rd = ins[11:7];
		f3 = ins[14:12];
		a = x[ins[19:15]];
		b = x[ins[24:20]];
		ii = {{20{ins[31]}}, ins[31:20]};
		is = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		ib = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
		iu = {ins[31:12], 12'd0};
		ij = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
		clean = {ins[31], ins[29:25]} == 6'd0;
		npc = pc + 32'd4;
		case (ins[6:0])
			opc_lui: write_reg(rd, iu);
			opc_auipc: write_reg(rd, pc + iu);
			opc_jal: begin
				write_reg(rd, pc + 32'd4);
				npc = pc + ij;
				if (ij == 32'd0)
					done = 1'b1; // final self-jump
			end
			opc_jalr: begin
				if (f3 == 3'd0) begin
					write_reg(rd, pc + 32'd4);
					npc = (a + ii) & ~32'd1;
				end
			end
			opc_branch: begin
				case (f3)
					3'd0: take = a == b;
					3'd1: take = a != b;
					3'd4: take = $signed(a) < $signed(b);
					3'd5: take = $signed(a) >= $signed(b);
					3'd6: take = a < b;
					3'd7: take = a >= b;
					default: take = 1'b0;
				endcase
				if (take)
					npc = pc + ib;
			end
			opc_load: begin
				if (f3 != 3'd3 && f3 < 3'd6) begin
					expect_data = 1'b1;
					d_store = 1'b0;
					d_addr = a + ii;
					d_f3 = f3;
					d_rd = rd;
				end
			end
			opc_store: begin
				if (f3 < 3'd3) begin
					expect_data = 1'b1;
					d_store = 1'b1;
					d_addr = a + is;
					d_f3 = f3;
					d_val = b;
				end
			end
			opc_op_imm: begin
				if (!((f3 == 3'd1 && !(clean && !ins[30])) || (f3 == 3'd5 && !clean)))
					write_reg(rd, alu_model(f3, f3 == 3'd5 && ins[30], a, ii));
			end
			opc_op: begin
				if (clean && (!ins[30] || f3 == 3'd0 || f3 == 3'd5))
					write_reg(rd, alu_model(f3, ins[30], a, b));
			end
			default: ; // unknown opcodes fall through as no-ops
		endcase
		pc = npc;
	endtask

	task automatic data_access();
		logic [31:0] exp_d, sh, v;
		logic [3:0] strb;
		logic [1:0] off;
		logic [9:0] idx;
		off = d_addr[1:0];
		idx = d_addr[11:2];
		check_value("data_addr", {d_addr[31:2], 2'b00}, mem_addr);
		if (!known[idx]) begin
			mem_copy[idx] = mem_rdata; // memory returns the old word on writes too
			known[idx] = 1'b1;
		end
		if (d_store) begin
			case (d_f3)
				3'd0: begin
					exp_d = {24'd0, d_val[7:0]} << (8 * off);
					strb = 4'b0001 << off;
				end
				3'd1: begin
					exp_d = {16'd0, d_val[15:0]} << (8 * off);
					strb = 4'b0011 << off;
				end
				default: begin
					exp_d = d_val;
					strb = 4'b1111;
				end
			endcase
			check_value("store_we", 32'd1, {31'd0, mem_we});
			check_value("store_wstrb", {28'd0, strb}, {28'd0, mem_wstrb});
			check_value("store_wdata", exp_d, mem_wdata);
			for (int k = 0; k < 4; k++)
				if (strb[k])
					mem_copy[idx][8*k +: 8] = exp_d[8*k +: 8];
		end else begin
			check_value("load_we", 32'd0, {31'd0, mem_we});
			sh = mem_copy[idx] >> (8 * off);
			case (d_f3)
				3'd0: v = {{24{sh[7]}}, sh[7:0]};
				3'd1: v = {{16{sh[15]}}, sh[15:0]};
				3'd4: v = {24'd0, sh[7:0]};
				3'd5: v = {16'd0, sh[15:0]};
				default: v = mem_copy[idx];
			endcase
			write_reg(d_rd, v);
		end
		expect_data = 1'b0;
	endtask

	always @(posedge clk) begin
		if (!rstn) begin
			if (mem_req)
				report_failure("mem_req was high while rstn was low");
			pc = 32'd0;
			expect_data = 1'b0;
			served = 1'b0;
			prev_req = 1'b0;
			done = 1'b0;
			for (int i = 0; i < 32; i++)
				x[i] = 32'd0;
			for (int i = 0; i < 1024; i++)
				known[i] = 1'b0;
		end else begin
			if (prev_req && mem_req && {mem_addr, mem_we, mem_wstrb, mem_wdata} != prev_bus)
				report_failure("request fields changed while mem_req was high");
			if (!prev_req && mem_req && mem_ack)
				report_failure("mem_req rose while mem_ack was still high");
			if (mem_req && mem_ack && !served) begin
				served = 1'b1;
				if (expect_data)
					data_access();
				else
					fetch_and_execute();
			end
			if (!mem_req)
				served = 1'b0;
			prev_req = mem_req;
			prev_bus = {mem_addr, mem_we, mem_wstrb, mem_wdata};
		end
	end

endmodule

`default_nettype wire

//--- hdl/rv_core.sv
`default_nettype none
`timescale 1ns/1ps

module rv_core import rv_pkg::*; (
	input logic clk,
	input logic rstn,
	output logic mem_req,
	output logic [xlen-1:0] mem_addr,
	output logic mem_we,
	output logic [3:0] mem_wstrb,
	output logic [xlen-1:0] mem_wdata,
	input logic mem_ack,
	input logic [xlen-1:0] mem_rdata
);

	op_t op;
	logic [reg_addr_w-1:0] rd;
	logic [reg_addr_w-1:0] rs1_idx;
	logic [reg_addr_w-1:0] rs2_idx;
	logic [xlen-1:0] imm;
	logic [xlen-1:0] rs1_val;
	logic [xlen-1:0] rs2_val;
	logic [xlen-1:0] alu_result;
	logic [xlen-1:0] load_data;
	logic [xlen-1:0] fetch_word;
	logic [xlen-1:0] pc;
	logic [xlen-1:0] instr;
	logic [xlen-1:0] wb_data;
	logic wb_en;
	logic access_start;
	logic access_fetch;
	logic access_done;

	core_sequencer sequencer_inst (
		.clk(clk), .rstn(rstn),
		.op(op), .imm(imm), .rs1_val(rs1_val), .alu_result(alu_result),
		.load_data(load_data), .fetch_word(fetch_word), .access_done(access_done),
		.access_start(access_start), .access_fetch(access_fetch),
		.pc(pc), .instr(instr), .wb_data(wb_data), .wb_en(wb_en)
	);

	inst_decoder decoder_inst (
		.clk(clk), .rstn(rstn), .instr(instr),
		.op(op), .rd(rd), .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .imm(imm)
	);

	int_reg_file reg_file_inst (
		.clk(clk), .rstn(rstn),
		.rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rd(rd),
		.wb_en(wb_en), .wb_data(wb_data),
		.rs1_val(rs1_val), .rs2_val(rs2_val)
	);

	int_alu alu_inst (
		.clk(clk), .op(op),
		.rs1_val(rs1_val), .rs2_val(rs2_val), .imm(imm),
		.alu_result(alu_result)
	);

	load_store_unit lsu_inst (
		.clk(clk), .rstn(rstn),
		.access_start(access_start), .access_fetch(access_fetch),
		.pc(pc), .rs1_val(rs1_val), .rs2_val(rs2_val), .imm(imm), .op(op),
		.access_done(access_done), .fetch_word(fetch_word), .load_data(load_data),
		.mem_req(mem_req), .mem_addr(mem_addr), .mem_we(mem_we),
		.mem_wstrb(mem_wstrb), .mem_wdata(mem_wdata),
		.mem_ack(mem_ack), .mem_rdata(mem_rdata)
	);

endmodule

`default_nettype wire

//--- hdl/load_store_unit.sv
`default_nettype none
`timescale 1ns/1ps

module load_store_unit import rv_pkg::*; (
	input logic clk,
	input logic rstn,
	input logic access_start,
	input logic access_fetch,
	input logic [xlen-1:0] pc,
	input logic [xlen-1:0] rs1_val,
	input logic [xlen-1:0] rs2_val,
	input logic [xlen-1:0] imm,
	input op_t op,
	output logic access_done,
	output logic [xlen-1:0] fetch_word,
	output logic [xlen-1:0] load_data,
	output logic mem_req,
	output logic [xlen-1:0] mem_addr,
	output logic mem_we,
	output logic [3:0] mem_wstrb,
	output logic [xlen-1:0] mem_wdata,
	input logic mem_ack,
	input logic [xlen-1:0] mem_rdata
);

	typedef enum logic [1:0] {ls_idle, ls_req, ls_ack_low} ls_state_t;

	ls_state_t ls_state;
	logic fetch_q;
	logic [1:0] off_q; // byte offset in the word
	logic [xlen-1:0] addr;
	logic store;
	logic [xlen-1:0] wdata_n;
	logic [3:0] wstrb_n;
	logic [xlen-1:0] rd_shift;
	logic [xlen-1:0] load_n;

	assign addr = access_fetch ? pc : rs1_val + imm;
	assign store = !access_fetch && is_store(op);

	always_comb begin
		case (op)
			op_sb: begin
				wdata_n = {24'd0, rs2_val[7:0]} << {addr[1:0], 3'b000};
				wstrb_n = 4'b0001 << addr[1:0];
			end
			op_sh: begin
				wdata_n = {16'd0, rs2_val[15:0]} << {addr[1], 4'b0000};
				wstrb_n = 4'b0011 << {addr[1], 1'b0};
			end
			default: begin
				wdata_n = rs2_val;
				wstrb_n = 4'b1111;
			end
		endcase
	end

	assign rd_shift = mem_rdata >> {off_q, 3'b000};

	always_comb begin
		case (op)
			op_lb: load_n = {{24{rd_shift[7]}}, rd_shift[7:0]};
			op_lh: load_n = {{16{rd_shift[15]}}, rd_shift[15:0]};
			op_lbu: load_n = {24'd0, rd_shift[7:0]};
			op_lhu: load_n = {16'd0, rd_shift[15:0]};
			default: load_n = mem_rdata;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			ls_state <= ls_idle;
			mem_req <= 1'b0;
			mem_we <= 1'b0;
			mem_wstrb <= '0;
			access_done <= 1'b0;
		end else begin
			access_done <= 1'b0;
			case (ls_state)
				ls_idle: begin
					if (access_start) begin
						mem_req <= 1'b1;
						mem_addr <= {addr[xlen-1:2], 2'b00};
						mem_we <= store;
						mem_wstrb <= store ? wstrb_n : 4'b0000;
						mem_wdata <= wdata_n;
						fetch_q <= access_fetch;
						off_q <= addr[1:0];
						ls_state <= ls_req;
					end
				end
				ls_req: begin
					if (mem_ack) begin
						if (fetch_q)
							fetch_word <= mem_rdata;
						else
							load_data <= load_n;
						mem_req <= 1'b0;
						ls_state <= ls_ack_low;
					end
				end
				default: begin
					if (!mem_ack) begin // handshake closed
						access_done <= 1'b1;
						ls_state <= ls_idle;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/int_alu.sv
`default_nettype none
`timescale 1ns/1ps

module int_alu import rv_pkg::*; (
	input logic clk,
	input op_t op,
	input logic [xlen-1:0] rs1_val,
	input logic [xlen-1:0] rs2_val,
	input logic [xlen-1:0] imm,
	output logic [xlen-1:0] alu_result
);

	logic [xlen-1:0] b;
	logic [4:0] shamt;
	logic [xlen-1:0] res;

	assign b = (is_reg_op(op) || is_branch(op)) ? rs2_val : imm;
	assign shamt = b[4:0];

	always_comb begin
		case (op)
			op_sub: res = rs1_val - b;
			op_slt, op_slti: res = {31'd0, $signed(rs1_val) < $signed(b)};
			op_sltu, op_sltiu: res = {31'd0, rs1_val < b};
			op_xor, op_xori: res = rs1_val ^ b;
			op_or, op_ori: res = rs1_val | b;
			op_and, op_andi: res = rs1_val & b;
			op_sll, op_slli: res = rs1_val << shamt;
			op_srl, op_srli: res = rs1_val >> shamt;
			op_sra, op_srai: res = $signed(rs1_val) >>> shamt;
			op_beq: res = {31'd0, rs1_val == b}; // branch condition as 0/1
			op_bne: res = {31'd0, rs1_val != b};
			op_blt: res = {31'd0, $signed(rs1_val) < $signed(b)};
			op_bge: res = {31'd0, $signed(rs1_val) >= $signed(b)};
			op_bltu: res = {31'd0, rs1_val < b};
			op_bgeu: res = {31'd0, rs1_val >= b};
			default: res = rs1_val + b;
		endcase
	end

	always_ff @(posedge clk) begin
		alu_result <= res;
	end

endmodule

`default_nettype wire

//--- hdl/int_reg_file.sv
`default_nettype none
`timescale 1ns/1ps

module int_reg_file import rv_pkg::*; (
	input logic clk,
	input logic rstn,
	input logic [reg_addr_w-1:0] rs1_idx,
	input logic [reg_addr_w-1:0] rs2_idx,
	input logic [reg_addr_w-1:0] rd,
	input logic wb_en,
	input logic [xlen-1:0] wb_data,
	output logic [xlen-1:0] rs1_val,
	output logic [xlen-1:0] rs2_val
);

	logic [xlen-1:0] regs [nregs];

	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int i = 0; i < nregs; i++)
				regs[i] <= '0;
			rs1_val <= '0;
			rs2_val <= '0;
		end else begin
			if (wb_en && rd != '0)
				regs[rd] <= wb_data; // x0 stays zero
			rs1_val <= (rs1_idx == '0) ? '0 : regs[rs1_idx];
			rs2_val <= (rs2_idx == '0) ? '0 : regs[rs2_idx];
		end
	end

endmodule

`default_nettype wire

//--- hdl/inst_decoder.sv
`default_nettype none
`timescale 1ns/1ps

module inst_decoder import rv_pkg::*; (
	input logic clk,
	input logic rstn,
	input logic [xlen-1:0] instr,
	output op_t op,
	output logic [reg_addr_w-1:0] rd,
	output logic [reg_addr_w-1:0] rs1_idx,
	output logic [reg_addr_w-1:0] rs2_idx,
	output logic [xlen-1:0] imm
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic f7_clean; // funct7 zero apart from bit 30
	logic [xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
	op_t op_n;
	logic [xlen-1:0] imm_n;
	logic writes_rd;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign f7_clean = {instr[31], instr[29:25]} == 6'd0;

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'd0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		op_n = op_nop; // csr, fence, anything unknown
		imm_n = '0;
		case (opcode)
			opc_lui: begin op_n = op_lui; imm_n = imm_u; end
			opc_auipc: begin op_n = op_auipc; imm_n = imm_u; end
			opc_jal: begin op_n = op_jal; imm_n = imm_j; end
			opc_jalr: begin
				imm_n = imm_i;
				if (funct3 == 3'b000)
					op_n = op_jalr;
			end
			opc_branch: begin
				imm_n = imm_b;
				case (funct3)
					3'b000: op_n = op_beq;
					3'b001: op_n = op_bne;
					3'b100: op_n = op_blt;
					3'b101: op_n = op_bge;
					3'b110: op_n = op_bltu;
					3'b111: op_n = op_bgeu;
					default: op_n = op_nop;
				endcase
			end
			opc_load: begin
				imm_n = imm_i;
				case (funct3)
					3'b000: op_n = op_lb;
					3'b001: op_n = op_lh;
					3'b010: op_n = op_lw;
					3'b100: op_n = op_lbu;
					3'b101: op_n = op_lhu;
					default: op_n = op_nop;
				endcase
			end
			opc_store: begin
				imm_n = imm_s;
				case (funct3)
					3'b000: op_n = op_sb;
					3'b001: op_n = op_sh;
					3'b010: op_n = op_sw;
					default: op_n = op_nop;
				endcase
			end
			opc_op_imm: begin
				imm_n = imm_i;
				case (funct3)
					3'b000: op_n = op_addi;
					3'b010: op_n = op_slti;
					3'b011: op_n = op_sltiu;
					3'b100: op_n = op_xori;
					3'b110: op_n = op_ori;
					3'b111: op_n = op_andi;
					3'b001: op_n = (f7_clean && !instr[30]) ? op_slli : op_nop;
					default: op_n = !f7_clean ? op_nop : instr[30] ? op_srai : op_srli;
				endcase
			end
			opc_op: begin
				if (f7_clean) begin
					case (funct3)
						3'b000: op_n = instr[30] ? op_sub : op_add;
						3'b101: op_n = instr[30] ? op_sra : op_srl;
						3'b001: op_n = instr[30] ? op_nop : op_sll;
						3'b010: op_n = instr[30] ? op_nop : op_slt;
						3'b011: op_n = instr[30] ? op_nop : op_sltu;
						3'b100: op_n = instr[30] ? op_nop : op_xor;
						3'b110: op_n = instr[30] ? op_nop : op_or;
						default: op_n = instr[30] ? op_nop : op_and;
					endcase
				end
			end
			default: op_n = op_nop;
		endcase
	end

	assign writes_rd = !(op_n == op_nop || is_branch(op_n) || is_store(op_n));

	always_ff @(posedge clk) begin
		if (!rstn) begin
			op <= op_nop;
			rd <= '0;
		end else begin
			op <= op_n;
			rd <= writes_rd ? instr[11:7] : '0;
		end
		rs1_idx <= instr[19:15];
		rs2_idx <= instr[24:20];
		imm <= imm_n;
	end

endmodule

`default_nettype wire

//--- hdl/core_sequencer.sv
`default_nettype none
`timescale 1ns/1ps

module core_sequencer import rv_pkg::*; (
	input logic clk,
	input logic rstn,
	input op_t op,
	input logic [xlen-1:0] imm,
	input logic [xlen-1:0] rs1_val,
	input logic [xlen-1:0] alu_result,
	input logic [xlen-1:0] load_data,
	input logic [xlen-1:0] fetch_word,
	input logic access_done,
	output logic access_start,
	output logic access_fetch,
	output logic [xlen-1:0] pc,
	output logic [xlen-1:0] instr,
	output logic [xlen-1:0] wb_data,
	output logic wb_en
);

	seq_state_t state;
	logic access_busy; // lsu owns the bus
	logic [xlen-1:0] pc_plus4;
	logic [xlen-1:0] pc_plus_imm;
	logic [xlen-1:0] jalr_target;
	logic [xlen-1:0] next_pc;

	assign pc_plus4 = pc + 32'd4;
	assign pc_plus_imm = pc + imm;
	assign jalr_target = rs1_val + imm;

	always_comb begin
		case (op)
			op_lui: wb_data = imm;
			op_auipc: wb_data = pc_plus_imm;
			op_jal, op_jalr: wb_data = pc_plus4; // link
			op_lb, op_lh, op_lw, op_lbu, op_lhu: wb_data = load_data;
			default: wb_data = alu_result;
		endcase
	end

	always_comb begin
		if (op == op_jal)
			next_pc = pc_plus_imm;
		else if (op == op_jalr)
			next_pc = {jalr_target[xlen-1:1], 1'b0};
		else if (is_branch(op) && alu_result != '0)
			next_pc = pc_plus_imm; // taken
		else
			next_pc = pc_plus4;
	end

	assign wb_en = (state == st_write); // rd is 0 when nothing is written

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= st_fetch;
			access_start <= 1'b0;
			access_fetch <= 1'b0;
			access_busy <= 1'b0;
			pc <= '0;
		end else begin
			access_start <= 1'b0;
			case (state)
				st_fetch: begin
					if (!access_busy) begin
						access_start <= 1'b1;
						access_fetch <= 1'b1;
						access_busy <= 1'b1;
					end else if (access_done) begin
						access_busy <= 1'b0;
						state <= st_decode;
					end
				end
				st_decode: state <= st_read;
				st_read: state <= st_exec;
				st_exec: begin
					if (is_load(op) || is_store(op)) begin
						access_start <= 1'b1;
						access_fetch <= 1'b0;
						access_busy <= 1'b1;
					end
					state <= st_mem;
				end
				st_mem: begin
					if (!access_busy || access_done) begin
						access_busy <= 1'b0;
						state <= st_write;
					end
				end
				st_write: begin
					pc <= next_pc;
					state <= st_fetch;
				end
				default: state <= st_fetch;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_fetch && access_busy && access_done)
			instr <= fetch_word;
	end

endmodule

`default_nettype wire

//--- hdl/rv_pkg.sv
`default_nettype none

package rv_pkg;

	localparam int xlen = 32;
	localparam int reg_addr_w = 5;
	localparam int nregs = 32;

	// major opcodes
	localparam logic [6:0] opc_lui = 7'b0110111;
	localparam logic [6:0] opc_auipc = 7'b0010111;
	localparam logic [6:0] opc_jal = 7'b1101111;
	localparam logic [6:0] opc_jalr = 7'b1100111;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_load = 7'b0000011;
	localparam logic [6:0] opc_store = 7'b0100011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_op = 7'b0110011;

	// groups stay contiguous, the range checks below rely on it
	typedef enum logic [5:0] {
		op_nop,
		op_lui, op_auipc, op_jal, op_jalr,
		op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
		op_lb, op_lh, op_lw, op_lbu, op_lhu,
		op_sb, op_sh, op_sw,
		op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi,
		op_slli, op_srli, op_srai,
		op_add, op_sub, op_sll, op_slt, op_sltu,
		op_xor, op_srl, op_sra, op_or, op_and
	} op_t;

	typedef enum logic [2:0] {
		st_fetch, st_decode, st_read, st_exec, st_mem, st_write
	} seq_state_t;

	function automatic logic is_branch(input op_t op);
		return op inside {[op_beq:op_bgeu]};
	endfunction

	function automatic logic is_load(input op_t op);
		return op inside {[op_lb:op_lhu]};
	endfunction

	function automatic logic is_store(input op_t op);
		return op inside {[op_sb:op_sw]};
	endfunction

	function automatic logic is_reg_op(input op_t op);
		return op inside {[op_add:op_and]};
	endfunction

endpackage

`default_nettype wire
